// ==== verilog/clb_pkg.sv ====
/*
 * calibration package
 * sample and bus types, channel counts
 * register word map of the gain and offset bank
 */

package clb_pkg;

  //////////////////////////////////////////////////////////////////////
  // sample widths and types
  //////////////////////////////////////////////////////////////////////

  localparam int gen_dw = 14;
  localparam int osc_dw = 16;

  typedef logic signed [gen_dw-1:0] gen_sample_t;
  typedef logic signed [osc_dw-1:0] osc_sample_t;

  // channel counts
  localparam int num_gen = 2;
  localparam int num_osc = 2;

  // unity gain, 1 << (width - 2)
  localparam gen_sample_t gen_unity = gen_sample_t'(1 << (gen_dw - 2));
  localparam osc_sample_t osc_unity = osc_sample_t'(1 << (osc_dw - 2));

  //////////////////////////////////////////////////////////////////////
  // system bus and register map
  //////////////////////////////////////////////////////////////////////

  typedef logic [31:0] bus_addr_t;
  typedef logic [31:0] bus_data_t;
  typedef logic [2:0]  reg_idx_t;

  // word index sits in byte address bits 4..2
  localparam int reg_idx_lsb = 2;
  localparam int reg_idx_msb = 4;

  // word = base + 2*channel + sel
  localparam int reg_osc_base  = 0;
  localparam int reg_gen_base  = 2 * num_osc;
  localparam int reg_gain_sel  = 0;
  localparam int reg_offs_sel  = 1;
  localparam int reg_num_words = 2 * (num_osc + num_gen);

endpackage

// ==== verilog/stream_if.sv ====
/*
 * sample stream interface
 * data, last, valid, ready with source and sink views
 */

`timescale 1ns/1ps

interface stream_if #(
  // sample width
  parameter int dw = 14
) ();

  // payload
  logic signed [dw-1:0] data;
  logic                 last;
  // handshake
  logic                 valid;
  logic                 ready;

  // producer side
  modport source (
    output data, last, valid,
    input  ready
  );

  // consumer side
  modport sink (
    input  data, last, valid,
    output ready
  );

endinterface

// ==== verilog/cfg_bus_if.sv ====
/*
 * system bus interface
 * single-cycle wen/ren strobes, registered ack, rdata and err
 */

`timescale 1ns/1ps

interface cfg_bus_if ();

  // request, driven by the master
  clb_pkg::bus_addr_t addr;
  clb_pkg::bus_data_t wdata;
  logic               wen;
  logic               ren;

  // response, one cycle after the strobe
  clb_pkg::bus_data_t rdata;
  logic               ack;
  logic               err;

  // top level side
  modport master (
    output addr, wdata, wen, ren,
    input  rdata, ack, err
  );

  // register bank side
  modport slave (
    input  addr, wdata, wen, ren,
    output rdata, ack, err
  );

endinterface

// ==== verilog/lin_mul.sv ====
/*
 * gain stage
 * signed multiply, shift by dw-2, saturate, one pipeline register
 */

`timescale 1ns/1ps

module lin_mul #(
  // sample width, at least 3
  parameter int dw = 14
) (
  input  logic                 bus,
  input  logic                 arst_n,
  stream_if.sink               sti,
  stream_if.source             sto,
  input  logic signed [dw-1:0] gain
);

  // full product width
  localparam int pw = 2 * dw;

  // saturation limits
  localparam logic signed [dw-1:0] max_val = {1'b0, {(dw-1){1'b1}}};
  localparam logic signed [dw-1:0] min_val = {1'b1, {(dw-1){1'b0}}};

  logic signed [pw-1:0] prod;
  logic signed [pw-1:0] shifted;
  logic                 ovf;
  logic signed [dw-1:0] sat;

  //////////////////////////////////////////////////////////////////////
  // arithmetic
  //////////////////////////////////////////////////////////////////////

  // both operands signed, so the product is sign extended to pw
  assign prod = sti.data * gain;

  // arithmetic shift floors, i.e. rounds toward minus infinity
  assign shifted = prod >>> (dw - 2);

  // fits only if bits pw-1..dw-1 are all equal
  assign ovf = ~((&shifted[pw-1:dw-1]) | ~(|shifted[pw-1:dw-1]));

  // clamp to the range, direction from the sign
  assign sat = ovf ? (shifted[pw-1] ? min_val : max_val) : shifted[dw-1:0];

  //////////////////////////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////////////////////////

  // take a beat when empty or when the held one leaves
  assign sti.ready = ~sto.valid | sto.ready;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      sto.valid <= 1'b0;
    end else if (sti.ready) begin
      sto.valid <= sti.valid;
    end
  end

  // payload only moves on a transfer
  always_ff @(posedge bus) begin
    if (sti.ready && sti.valid) begin
      sto.data <= sat;
      sto.last <= sti.last;
    end
  end

endmodule

// ==== verilog/lin_add.sv ====
/*
 * offset stage
 * signed add with one guard bit, saturate, one pipeline register
 */

`timescale 1ns/1ps

module lin_add #(
  // sample width, at least 3
  parameter int dw = 14
) (
  input  logic                 bus,
  input  logic                 arst_n,
  stream_if.sink               sti,
  stream_if.source             sto,
  input  logic signed [dw-1:0] offset
);

  // saturation limits
  localparam logic signed [dw-1:0] max_val = {1'b0, {(dw-1){1'b1}}};
  localparam logic signed [dw-1:0] min_val = {1'b1, {(dw-1){1'b0}}};

  logic signed [dw:0]   sum;
  logic                 ovf;
  logic signed [dw-1:0] sat;

  //////////////////////////////////////////////////////////////////////
  // arithmetic
  //////////////////////////////////////////////////////////////////////

  // one extra bit, cannot wrap
  assign sum = {sti.data[dw-1], sti.data} + {offset[dw-1], offset};

  // top two bits differ -> out of range
  assign ovf = sum[dw] ^ sum[dw-1];

  // sign of the wide sum picks the limit
  assign sat = ovf ? (sum[dw] ? min_val : max_val) : sum[dw-1:0];

  //////////////////////////////////////////////////////////////////////
  // pipeline register
  //////////////////////////////////////////////////////////////////////

  // same rule as the gain stage, ready passes straight back
  assign sti.ready = ~sto.valid | sto.ready;

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      sto.valid <= 1'b0;
    end else if (sti.ready) begin
      sto.valid <= sti.valid;
    end
  end

  always_ff @(posedge bus) begin
    if (sti.ready && sti.valid) begin
      sto.data <= sat;
      sto.last <= sti.last;
    end
  end

endmodule

// ==== verilog/clb_regs.sv ====
/*
 * calibration register bank
 * gain and offset words per channel, write decode, read mux
 * registered ack, rdata and err
 */

`timescale 1ns/1ps

module clb_regs (
  input  logic                                          bus,
  input  logic                                          arst_n,
  cfg_bus_if.slave                                      cfg,
  output clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0]   gen_gain,
  output clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0]   gen_offset,
  output clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0]   osc_gain,
  output clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0]   osc_offset
);

  clb_pkg::reg_idx_t  idx;
  clb_pkg::bus_data_t rd_mux;

  // word index, upper address bits ignored so the map repeats
  assign idx = cfg.addr[clb_pkg::reg_idx_msb:clb_pkg::reg_idx_lsb];

  //////////////////////////////////////////////////////////////////////
  // write decode
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      // unity gain, zero offset
      for (int i = 0; i < clb_pkg::num_gen; i++) begin
        gen_gain[i]   <= clb_pkg::gen_unity;
        gen_offset[i] <= '0;
      end
      for (int i = 0; i < clb_pkg::num_osc; i++) begin
        osc_gain[i]   <= clb_pkg::osc_unity;
        osc_offset[i] <= '0;
      end
    end else if (cfg.wen) begin
      // only the low sample bits of wdata are kept
      for (int i = 0; i < clb_pkg::num_gen; i++) begin
        if (idx == clb_pkg::reg_gen_base + 2*i + clb_pkg::reg_gain_sel)
          gen_gain[i] <= cfg.wdata[clb_pkg::gen_dw-1:0];
        if (idx == clb_pkg::reg_gen_base + 2*i + clb_pkg::reg_offs_sel)
          gen_offset[i] <= cfg.wdata[clb_pkg::gen_dw-1:0];
      end
      for (int i = 0; i < clb_pkg::num_osc; i++) begin
        if (idx == clb_pkg::reg_osc_base + 2*i + clb_pkg::reg_gain_sel)
          osc_gain[i] <= cfg.wdata[clb_pkg::osc_dw-1:0];
        if (idx == clb_pkg::reg_osc_base + 2*i + clb_pkg::reg_offs_sel)
          osc_offset[i] <= cfg.wdata[clb_pkg::osc_dw-1:0];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read mux and response
  //////////////////////////////////////////////////////////////////////

  // signed words widen with sign extension on assignment
  always_comb begin
    rd_mux = '0;
    for (int i = 0; i < clb_pkg::num_gen; i++) begin
      if (idx == clb_pkg::reg_gen_base + 2*i + clb_pkg::reg_gain_sel) rd_mux = gen_gain[i];
      if (idx == clb_pkg::reg_gen_base + 2*i + clb_pkg::reg_offs_sel) rd_mux = gen_offset[i];
    end
    for (int i = 0; i < clb_pkg::num_osc; i++) begin
      if (idx == clb_pkg::reg_osc_base + 2*i + clb_pkg::reg_gain_sel) rd_mux = osc_gain[i];
      if (idx == clb_pkg::reg_osc_base + 2*i + clb_pkg::reg_offs_sel) rd_mux = osc_offset[i];
    end
  end

  // ack one cycle after either strobe
  // err flags words past the end of the map, none with 8 words
  always_ff @(posedge bus or negedge arst_n) begin
    if (!arst_n) begin
      cfg.ack <= 1'b0;
      cfg.err <= 1'b0;
    end else begin
      cfg.ack <= cfg.wen | cfg.ren;
      cfg.err <= (cfg.wen | cfg.ren) & (idx >= clb_pkg::reg_num_words);
    end
  end

  // read data lines up with ack
  always_ff @(posedge bus) begin
    if (cfg.ren) begin
      cfg.rdata <= rd_mux;
    end
  end

endmodule

// ==== verilog/clb.sv ====
/*
 * calibration top level
 * gen chains: gain then offset, osc chains: offset then gain
 * register bank on the system bus
 */

`timescale 1ns/1ps

module clb (
  input  logic                                          bus,
  input  logic                                          arst_n,
  // generator streams in
  input  clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0]   gen_data,
  input  logic                 [clb_pkg::num_gen-1:0]   gen_last,
  input  logic                 [clb_pkg::num_gen-1:0]   gen_valid,
  output logic                 [clb_pkg::num_gen-1:0]   gen_ready,
  // DAC streams out
  output clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0]   dac_data,
  output logic                 [clb_pkg::num_gen-1:0]   dac_last,
  output logic                 [clb_pkg::num_gen-1:0]   dac_valid,
  input  logic                 [clb_pkg::num_gen-1:0]   dac_ready,
  // ADC streams in
  input  clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0]   adc_data,
  input  logic                 [clb_pkg::num_osc-1:0]   adc_last,
  input  logic                 [clb_pkg::num_osc-1:0]   adc_valid,
  output logic                 [clb_pkg::num_osc-1:0]   adc_ready,
  // oscilloscope streams out
  output clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0]   osc_data,
  output logic                 [clb_pkg::num_osc-1:0]   osc_last,
  output logic                 [clb_pkg::num_osc-1:0]   osc_valid,
  input  logic                 [clb_pkg::num_osc-1:0]   osc_ready,
  // system bus
  input  clb_pkg::bus_addr_t                            bus_addr,
  input  clb_pkg::bus_data_t                            bus_wdata,
  input  logic                                          bus_wen,
  input  logic                                          bus_ren,
  output clb_pkg::bus_data_t                            bus_rdata,
  output logic                                          bus_ack,
  output logic                                          bus_err
);

  // calibration levels from the bank
  clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0] gen_gain;
  clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0] gen_offset;
  clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0] osc_gain;
  clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0] osc_offset;

  //////////////////////////////////////////////////////////////////////
  // system bus and register bank
  //////////////////////////////////////////////////////////////////////

  cfg_bus_if cfg ();

  // plain ports onto the bus interface
  assign cfg.addr  = bus_addr;
  assign cfg.wdata = bus_wdata;
  assign cfg.wen   = bus_wen;
  assign cfg.ren   = bus_ren;
  assign bus_rdata = cfg.rdata;
  assign bus_ack   = cfg.ack;
  assign bus_err   = cfg.err;

  clb_regs u_regs (
    .bus        (bus),
    .arst_n     (arst_n),
    .cfg        (cfg),
    .gen_gain   (gen_gain),
    .gen_offset (gen_offset),
    .osc_gain   (osc_gain),
    .osc_offset (osc_offset)
  );

  //////////////////////////////////////////////////////////////////////
  // generator chains, gen -> mul -> add -> dac
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < clb_pkg::num_gen; i++) begin : g_gen
    stream_if #(.dw(clb_pkg::gen_dw)) gen_in ();
    stream_if #(.dw(clb_pkg::gen_dw)) gen_mid ();
    stream_if #(.dw(clb_pkg::gen_dw)) dac_out ();

    // input port side
    assign gen_in.data  = gen_data[i];
    assign gen_in.last  = gen_last[i];
    assign gen_in.valid = gen_valid[i];
    assign gen_ready[i] = gen_in.ready;

    lin_mul #(.dw(clb_pkg::gen_dw)) u_mul (
      .bus    (bus),
      .arst_n (arst_n),
      .sti    (gen_in),
      .sto    (gen_mid),
      .gain   (gen_gain[i])
    );

    lin_add #(.dw(clb_pkg::gen_dw)) u_add (
      .bus    (bus),
      .arst_n (arst_n),
      .sti    (gen_mid),
      .sto    (dac_out),
      .offset (gen_offset[i])
    );

    // DAC port side
    assign dac_data[i]   = dac_out.data;
    assign dac_last[i]   = dac_out.last;
    assign dac_valid[i]  = dac_out.valid;
    assign dac_out.ready = dac_ready[i];
  end

  //////////////////////////////////////////////////////////////////////
  // oscilloscope chains, adc -> add -> mul -> osc
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < clb_pkg::num_osc; i++) begin : g_osc
    stream_if #(.dw(clb_pkg::osc_dw)) adc_in ();
    stream_if #(.dw(clb_pkg::osc_dw)) osc_mid ();
    stream_if #(.dw(clb_pkg::osc_dw)) osc_out ();

    assign adc_in.data  = adc_data[i];
    assign adc_in.last  = adc_last[i];
    assign adc_in.valid = adc_valid[i];
    assign adc_ready[i] = adc_in.ready;

    // offset first, reverse of the gen path
    lin_add #(.dw(clb_pkg::osc_dw)) u_add (
      .bus    (bus),
      .arst_n (arst_n),
      .sti    (adc_in),
      .sto    (osc_mid),
      .offset (osc_offset[i])
    );

    lin_mul #(.dw(clb_pkg::osc_dw)) u_mul (
      .bus    (bus),
      .arst_n (arst_n),
      .sti    (osc_mid),
      .sto    (osc_out),
      .gain   (osc_gain[i])
    );

    assign osc_data[i]   = osc_out.data;
    assign osc_last[i]   = osc_out.last;
    assign osc_valid[i]  = osc_out.valid;
    assign osc_out.ready = osc_ready[i];
  end

endmodule

// ==== tb/clb_tb_model.svh ====
/*
 * reference gain and offset arithmetic
 * per-channel beat buffers for the stream checks
 */

`ifndef CLB_TB_MODEL_SVH
`define CLB_TB_MODEL_SVH

// streams 0..1 gen, 2..3 osc
localparam int num_ch    = 4;
localparam int max_beats = 32;

logic [31:0] in_buf   [num_ch][max_beats];
logic [31:0] exp_buf  [num_ch][max_beats];
logic        last_buf [num_ch][max_beats];
int          acc_cyc  [num_ch][max_beats];
int          total    [num_ch];
int          sent     [num_ch];
int          recv     [num_ch];

// sample width of a stream
function automatic int ch_width(int c);
  return (c < 2) ? clb_pkg::gen_dw : clb_pkg::osc_dw;
endfunction

// clamp into the signed range of w bits
function automatic longint clamp(longint v, int w);
  longint hi;
  longint lo;
  hi = (longint'(1) <<< (w - 1)) - 1;
  lo = -(longint'(1) <<< (w - 1));
  if (v > hi) return hi;
  if (v < lo) return lo;
  return v;
endfunction

// low w bits of a raw field as a signed value
function automatic longint to_signed(logic [31:0] raw, int w);
  longint v;
  v = longint'(raw & ((32'h1 << w) - 1));
  if (raw[w-1]) v = v - (longint'(1) <<< w);
  return v;
endfunction

// unity is 1 << (w-2), floor of the scaled product
function automatic longint gain_ref(longint x, longint g, int w);
  return clamp((x * g) >>> (w - 2), w);
endfunction

function automatic longint offset_ref(longint x, longint o, int w);
  return clamp(x + o, w);
endfunction

// gen multiplies first, osc adds first
function automatic logic [31:0] chain_ref(int c, longint x, longint g, longint o);
  int     w;
  longint y;
  w = ch_width(c);
  if (c < 2) y = offset_ref(gain_ref(x, g, w), o, w);
  else y = gain_ref(offset_ref(x, o, w), g, w);
  return 32'(y) & ((32'h1 << w) - 1);
endfunction

`endif

// ==== tb/clb_tb.sv ====
/*
 * testbench for the calibration block
 * clock, reset, case file reader, bus and stream drivers, checks
 */

`timescale 1ns/1ps

module clb_tb;

  logic bus;
  logic arst_n;

  // flat view of the four streams, 0..1 gen and 2..3 osc
  logic [3:0]  in_v;
  logic [3:0]  in_last;
  logic [15:0] in_d [4];
  wire  [3:0]  in_rdy;
  wire  [3:0]  out_v;
  wire  [3:0]  out_last;
  wire  [15:0] out_d [4];
  logic [3:0]  out_rdy;

  clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0] gen_data;
  clb_pkg::gen_sample_t [clb_pkg::num_gen-1:0] dac_data;
  clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0] adc_data;
  clb_pkg::osc_sample_t [clb_pkg::num_osc-1:0] osc_data;

  clb_pkg::bus_addr_t bus_addr;
  clb_pkg::bus_data_t bus_wdata;
  logic               bus_wen;
  logic               bus_ren;
  clb_pkg::bus_data_t bus_rdata;
  logic               bus_ack;
  logic               bus_err;

  // expected register words, sign extended
  longint shadow [8];

  `include "clb_tb_model.svh"

  assign gen_data = {in_d[1][13:0], in_d[0][13:0]};
  assign adc_data = {in_d[3], in_d[2]};
  assign out_d[0] = {2'b00, dac_data[0]};
  assign out_d[1] = {2'b00, dac_data[1]};
  assign out_d[2] = osc_data[0];
  assign out_d[3] = osc_data[1];

  clb u_clb (
    .bus       (bus),
    .arst_n    (arst_n),
    .gen_data  (gen_data),
    .gen_last  (in_last[1:0]),
    .gen_valid (in_v[1:0]),
    .gen_ready (in_rdy[1:0]),
    .dac_data  (dac_data),
    .dac_last  (out_last[1:0]),
    .dac_valid (out_v[1:0]),
    .dac_ready (out_rdy[1:0]),
    .adc_data  (adc_data),
    .adc_last  (in_last[3:2]),
    .adc_valid (in_v[3:2]),
    .adc_ready (in_rdy[3:2]),
    .osc_data  (osc_data),
    .osc_last  (out_last[3:2]),
    .osc_valid (out_v[3:2]),
    .osc_ready (out_rdy[3:2]),
    .bus_addr  (bus_addr),
    .bus_wdata (bus_wdata),
    .bus_wen   (bus_wen),
    .bus_ren   (bus_ren),
    .bus_rdata (bus_rdata),
    .bus_ack   (bus_ack),
    .bus_err   (bus_err)
  );

  // 8 ns period
  always #4 bus = ~bus;

  //////////////////////////////////////////////////////////////////////
  // helpers
  //////////////////////////////////////////////////////////////////////

  task automatic abort_run();
    $display("Something failed");
    $fatal(1);
  endtask

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("[ERROR] %s got %h expected %h", name, got, exp);
      abort_run();
    end
  endtask

  // osc words 0..3, gen words 4..7
  function automatic int word_w(int idx);
    return (idx < 4) ? clb_pkg::osc_dw : clb_pkg::gen_dw;
  endfunction

  // gain word (sel 0) or offset word (sel 1) of a stream
  function automatic int word_of(int c, int sel);
    return (c < 2) ? 4 + 2*c + sel : 2*(c - 2) + sel;
  endfunction

  // one strobe with the ack due on the very next cycle
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] data, output logic [31:0] rdata);
    int waited;
    @(posedge bus);
    #1;
    bus_addr  = addr;
    bus_wdata = data;
    bus_wen   = wr;
    bus_ren   = !wr;
    // no response before the strobe is sampled
    @(negedge bus);
    check("bus_ack", bus_ack, 0);
    @(posedge bus);
    #1;
    bus_wen = 1'b0;
    bus_ren = 1'b0;
    waited  = 0;
    @(negedge bus);
    while (bus_ack !== 1'b1) begin
      waited++;
      if (waited > 10) begin
        $display("bus access to address %h was never acknowledged", addr);
        abort_run();
      end
      @(negedge bus);
    end
    check("bus_ack delay", waited, 0);
    check("bus_err", bus_err, 0);
    rdata = bus_rdata;
    // ack is a single-cycle pulse
    @(negedge bus);
    check("bus_ack", bus_ack, 0);
  endtask

  // file value cross-checked against the reference chain
  task automatic queue_beat(input int c, input logic last, input logic [31:0] din,
                            input logic [31:0] dexp);
    check($sformatf("case file expected, stream %0d", c), dexp,
          chain_ref(c, to_signed(din, ch_width(c)),
                    shadow[word_of(c, 0)], shadow[word_of(c, 1)]));
    in_buf[c][total[c]]   = din;
    exp_buf[c][total[c]]  = dexp;
    last_buf[c][total[c]] = last;
    total[c]++;
  endtask

  //////////////////////////////////////////////////////////////////////
  // stream driver and monitor
  //////////////////////////////////////////////////////////////////////

  // drive after the rising edge and sample handshakes at the falling edge
  task automatic run_streams(input int pacing);
    int         cyc;
    bit         busy;
    logic [3:0] in_fire;
    logic [3:0] out_fire;
    cyc     = 0;
    busy    = 1'b1;
    in_fire = '0;
    while (busy) begin
      if (cyc > 2000) begin
        $display("streams did not drain within 2000 cycles");
        abort_run();
      end
      @(posedge bus);
      #1;
      for (int c = 0; c < num_ch; c++) begin
        // an offered beat holds until taken
        if (!(in_v[c] && !in_fire[c])) begin
          in_v[c]    = (sent[c] < total[c]) && (pacing == 0 || $urandom_range(3) != 0);
          in_d[c]    = in_buf[c][sent[c]][15:0];
          in_last[c] = last_buf[c][sent[c]];
        end
        out_rdy[c] = (pacing == 0) || ($urandom_range(2) != 0);
      end
      @(negedge bus);
      in_fire  = in_v & in_rdy;
      out_fire = out_v & out_rdy;
      busy     = 1'b0;
      for (int c = 0; c < num_ch; c++) begin
        if (in_fire[c]) begin
          acc_cyc[c][sent[c]] = cyc;
          sent[c]++;
        end
        if (out_fire[c]) begin
          if (recv[c] >= total[c]) begin
            $display("stream %0d produced a beat that was never sent", c);
            abort_run();
          end
          check($sformatf("%s[%0d]", (c < 2) ? "dac_data" : "osc_data", c % 2),
                out_d[c], exp_buf[c][recv[c]]);
          check($sformatf("%s[%0d]", (c < 2) ? "dac_last" : "osc_last", c % 2),
                out_last[c], last_buf[c][recv[c]]);
          // two stages at full throughput
          if (pacing == 0) check("chain latency", cyc - acc_cyc[c][recv[c]], 2);
          recv[c]++;
        end
        if (recv[c] < total[c]) busy = 1'b1;
      end
      cyc++;
    end
    for (int c = 0; c < num_ch; c++) begin
      total[c] = 0;
      sent[c]  = 0;
      recv[c]  = 0;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    int          fd;
    int          n;
    int          c;
    int          pacing;
    string       line;
    byte         kind;
    logic [31:0] f1;
    logic [31:0] f2;
    logic [31:0] f3;
    logic [31:0] f4;
    logic [31:0] rd;
    void'($urandom(32'h54bf_8980));
    bus       = 1'b0;
    arst_n    = 1'b0;
    in_v      = '0;
    in_last   = '0;
    out_rdy   = '1;
    bus_addr  = '0;
    bus_wdata = '0;
    bus_wen   = 1'b0;
    bus_ren   = 1'b0;
    pacing    = 0;
    for (int i = 0; i < num_ch; i++) begin
      in_d[i]  = '0;
      total[i] = 0;
      sent[i]  = 0;
      recv[i]  = 0;
    end
    // unity gains and zero offsets
    for (int i = 0; i < 8; i++) begin
      shadow[i] = (i % 2) ? 0 : (longint'(1) <<< (word_w(i) - 2));
    end
    repeat (16) @(posedge bus);
    #1;
    arst_n = 1'b1;

    fd = $fopen("tb/clb_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open tb/clb_cases.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line = "";
      n = $fgets(line, fd);
      if (n == 0 || line.len() < 2 || line[0] == "#") continue;
      n = $sscanf(line, "%c %h %h %h %h", kind, f1, f2, f3, f4);
      // levels only change with the chains empty
      if (kind == "W" || kind == "R" || kind == "P") run_streams(pacing);
      case (kind)
        "W": begin
          bus_access(1'b1, f1, f2, rd);
          shadow[f1[4:2]] = to_signed(f2, word_w(f1[4:2]));
        end
        "R": begin
          bus_access(1'b0, f1, '0, rd);
          check("bus_rdata", rd, f2);
          check("case file rdata", f2, 32'(shadow[f1[4:2]]));
        end
        "P": pacing = f1;
        "G", "O": begin
          c = (kind == "O") ? 2 + f1 : f1;
          queue_beat(c, f2[0], f3, f4);
        end
        default: begin
          $display("unknown line in case file: %s", line);
          abort_run();
        end
      endcase
    end
    run_streams(pacing);
    $fclose(fd);
    $display("Everything OK");
    $finish;
  end

endmodule

// ==== compile.f ====
+incdir+tb
verilog/clb_pkg.sv
verilog/stream_if.sv
verilog/cfg_bus_if.sv
verilog/lin_mul.sv
verilog/lin_add.sv
verilog/clb_regs.sv
verilog/clb.sv
tb/clb_tb.sv

// ==== tb/clb_cases.txt ====
# calibration cases, one per line, numbers in hex
# W addr wdata | R addr rdata | P pacing (0 ready high, 1 random)
# G/O ch last in exp, gen -> DAC and ADC -> osc samples
P 0
R 00000000 00004000
R 00000004 00000000
R 00000008 00004000
R 0000000c 00000000
R 00000010 00001000
R 00000014 00000000
R 00000018 00001000
R 0000001c 00000000
G 0 0 0123 0123
G 1 1 3e00 3e00
O 0 0 8001 8001
O 1 1 7fff 7fff
W 00000010 00000800
W 00000014 00003f00
R 00000034 ffffff00
W 000000f8 ffff2000
R 00000018 ffffe000
W 0000001c 00001000
W 00000000 00008000
R 00000020 ffff8000
W 00000004 00000100
W 00000008 00007fff
W 0000000c 0000c000
R 0000002c ffffc000
G 0 0 0400 0100
G 0 1 3fff 3eff
G 1 0 0010 0fe0
G 1 1 3000 1fff
O 0 0 0000 fe00
O 0 1 7f80 8000
O 1 0 8100 8000
O 1 1 3fff fffe
P 1
G 0 0 2000 2f00
G 0 1 1fff 0eff
G 1 0 1000 3000
G 1 1 1800 3000
O 0 0 8000 7fff
O 0 1 ffff fe02
O 1 0 5000 1fff
O 1 1 7fff 7ffd
